//--- common/icache_pkg.sv
// Widths, page geometry and register map shared by the instruction cache
// Byte addressed, 32-bit words, one cached page of 2**INDEX_W words
// INDEX_W and BUBBLE_CYCLES are only defaults, the top level may override them
package icache_pkg;

    // Bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    // Page geometry
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 2;
    localparam int PAGE_W   = ADDR_W - INDEX_W - OFFSET_W;

    // Branch bubble length on a miss
    localparam int BUBBLE_CYCLES = 5;

    // Region base value meaning no page is cached
    localparam logic [ADDR_W-1:0] REGION_NONE = '1;

    // Register offsets on the AXI4-Lite port
    localparam logic [3:0] REG_CTRL_OFFS   = 4'h0;
    localparam logic [3:0] REG_REGION_OFFS = 4'h4;

    // AXI response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

//--- hdl/icache_ram.sv
// Behavioral stand-in for the single-port SRAM macro
// Read data is registered, one cycle after the index, read before write
`timescale 1ns/1ns

module icache_ram
    import icache_pkg::*;
#(
    parameter int INDEX_W = icache_pkg::INDEX_W
)
(
    input  logic               clk,
    input  logic               i_we,
    input  logic [INDEX_W-1:0] i_index,
    input  logic [DATA_W-1:0]  i_wdata,
    output logic [DATA_W-1:0]  o_rdata
);

    logic [DATA_W-1:0] mem [2**INDEX_W];

    always_ff @(posedge clk)
    begin
        if (i_we)
            mem[i_index] <= i_wdata;
        o_rdata <= mem[i_index];
    end

    // An unknown index would corrupt an unpredictable word
    index_known: assert property (@(posedge clk)
        i_we |-> !$isunknown(i_index));

endmodule

//--- hdl/icache_regs.sv
// AXI4-Lite register block, CTRL holds the bypass bit, REGION is read only
// Address and data of a write must arrive together, one transfer at a time
// Unmapped offsets answer SLVERR, writes to REGION are dropped with OKAY
`timescale 1ns/1ns

module icache_regs
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:0]        i_awaddr,
    input  logic              i_awvalid,
    output logic              o_awready,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [3:0]        i_wstrb,
    input  logic              i_wvalid,
    output logic              o_wready,
    output logic [1:0]        o_bresp,
    output logic              o_bvalid,
    input  logic              i_bready,
    input  logic [3:0]        i_araddr,
    input  logic              i_arvalid,
    output logic              o_arready,
    output logic [DATA_W-1:0] o_rdata,
    output logic [1:0]        o_rresp,
    output logic              o_rvalid,
    input  logic              i_rready,
    input  logic [ADDR_W-1:0] i_region_base,
    output logic              o_bypass
);

    logic              wr_rdy_q;
    logic              rd_rdy_q;
    logic              wr_go;
    logic              rd_go;
    logic [1:0]        wr_resp;
    logic [1:0]        rd_resp;
    logic [DATA_W-1:0] rd_word;

    // One ready pulse per write, both channels at once
    assign o_awready = wr_rdy_q;
    assign o_wready  = wr_rdy_q;
    assign o_arready = rd_rdy_q;

    assign wr_go = wr_rdy_q && i_awvalid && i_wvalid;
    assign rd_go = rd_rdy_q && i_arvalid;

    assign wr_resp = (i_awaddr == REG_CTRL_OFFS || i_awaddr == REG_REGION_OFFS) ?
                     AXI_RESP_OKAY : AXI_RESP_SLVERR;

    // Read decode
    always_comb
    begin
        rd_word = '0;
        rd_resp = AXI_RESP_OKAY;
        case (i_araddr)
            REG_CTRL_OFFS:   rd_word = {{(DATA_W-1){1'b0}}, o_bypass};
            REG_REGION_OFFS: rd_word = i_region_base;
            default:         rd_resp = AXI_RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_rdy_q <= 1'b0;
            rd_rdy_q <= 1'b0;
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
            o_bypass <= 1'b0;
        end
        else
        begin
            // No new transfer while a response is still pending
            wr_rdy_q <= i_awvalid && i_wvalid && !wr_rdy_q && !o_bvalid;
            rd_rdy_q <= i_arvalid && !rd_rdy_q && !o_rvalid;

            if (wr_go)
                o_bvalid <= 1'b1;
            else if (i_bready)
                o_bvalid <= 1'b0;

            if (rd_go)
                o_rvalid <= 1'b1;
            else if (i_rready)
                o_rvalid <= 1'b0;

            // Only byte lane 0 carries the bypass bit
            if (wr_go && i_awaddr == REG_CTRL_OFFS && i_wstrb[0])
                o_bypass <= i_wdata[0];
        end
    end

    // Response payload
    always_ff @(posedge clk)
    begin
        if (wr_go)
            o_bresp <= wr_resp;
        if (rd_go)
        begin
            o_rdata <= rd_word;
            o_rresp <= rd_resp;
        end
    end

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

//--- hdl/icache_top.sv
// Instruction cache top level, one cached page in front of the flash master
// The core must hold i_pc_fetch stable while o_clk_enable is low
// Register port is AXI4-Lite with 4-bit offsets
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_W       = icache_pkg::INDEX_W,
    parameter int BUBBLE_CYCLES = icache_pkg::BUBBLE_CYCLES
)
(
    input  logic              clk,
    input  logic              rst_n,
    // Core side
    input  logic [ADDR_W-1:0] i_pc_fetch,
    output logic [DATA_W-1:0] o_code_fetch,
    output logic              o_clk_enable,
    output logic              o_i_cache_miss,
    output logic              o_core_bubble,
    // Flash master
    input  logic [DATA_W-1:0] i_spi_data,
    input  logic              i_spi_ready,
    output logic [ADDR_W-1:0] o_spi_address,
    output logic              o_spi_addr_valid,
    // AXI4-Lite slave
    input  logic [3:0]        i_awaddr,
    input  logic              i_awvalid,
    output logic              o_awready,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [3:0]        i_wstrb,
    input  logic              i_wvalid,
    output logic              o_wready,
    output logic [1:0]        o_bresp,
    output logic              o_bvalid,
    input  logic              i_bready,
    input  logic [3:0]        i_araddr,
    input  logic              i_arvalid,
    output logic              o_arready,
    output logic [DATA_W-1:0] o_rdata,
    output logic [1:0]        o_rresp,
    output logic              o_rvalid,
    input  logic              i_rready
);

    logic               bypass;
    logic [ADDR_W-1:0]  region_base;
    logic               ram_we;
    logic [INDEX_W-1:0] ram_index;
    logic [DATA_W-1:0]  ram_wdata;
    logic [DATA_W-1:0]  ram_rdata;

    icache_regs regs_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_awaddr      (i_awaddr),
        .i_awvalid     (i_awvalid),
        .o_awready     (o_awready),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .i_wvalid      (i_wvalid),
        .o_wready      (o_wready),
        .o_bresp       (o_bresp),
        .o_bvalid      (o_bvalid),
        .i_bready      (i_bready),
        .i_araddr      (i_araddr),
        .i_arvalid     (i_arvalid),
        .o_arready     (o_arready),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .o_rvalid      (o_rvalid),
        .i_rready      (i_rready),
        .i_region_base (region_base),
        .o_bypass      (bypass)
    );

    icache_fill_ctrl #(
        .INDEX_W       (INDEX_W),
        .BUBBLE_CYCLES (BUBBLE_CYCLES)
    ) fill_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_pc_fetch       (i_pc_fetch),
        .i_bypass         (bypass),
        .i_spi_data       (i_spi_data),
        .i_spi_ready      (i_spi_ready),
        .i_ram_rdata      (ram_rdata),
        .o_region_base    (region_base),
        .o_code_fetch     (o_code_fetch),
        .o_clk_enable     (o_clk_enable),
        .o_i_cache_miss   (o_i_cache_miss),
        .o_core_bubble    (o_core_bubble),
        .o_spi_address    (o_spi_address),
        .o_spi_addr_valid (o_spi_addr_valid),
        .o_ram_we         (ram_we),
        .o_ram_index      (ram_index),
        .o_ram_wdata      (ram_wdata)
    );

    icache_ram #(
        .INDEX_W (INDEX_W)
    ) ram_inst (
        .clk     (clk),
        .i_we    (ram_we),
        .i_index (ram_index),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

endmodule

//--- icache_fill/icache_fill_ctrl.sv
// Miss handling for the single cached page stalls the core through its clock enable
// A fill always streams the whole aligned page without critical word first
// In bypass every fetch waits for its own flash word
`timescale 1ns/1ns

module icache_fill_ctrl
    import icache_pkg::*;
#(
    parameter int INDEX_W       = icache_pkg::INDEX_W,
    parameter int BUBBLE_CYCLES = icache_pkg::BUBBLE_CYCLES
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [ADDR_W-1:0]  i_pc_fetch,
    input  logic               i_bypass,
    input  logic [DATA_W-1:0]  i_spi_data,
    input  logic               i_spi_ready,
    input  logic [DATA_W-1:0]  i_ram_rdata,
    output logic [ADDR_W-1:0]  o_region_base,
    output logic [DATA_W-1:0]  o_code_fetch,
    output logic               o_clk_enable,
    output logic               o_i_cache_miss,
    output logic               o_core_bubble,
    output logic [ADDR_W-1:0]  o_spi_address,
    output logic               o_spi_addr_valid,
    output logic               o_ram_we,
    output logic [INDEX_W-1:0] o_ram_index,
    output logic [DATA_W-1:0]  o_ram_wdata
);

    localparam int PG_LSB = INDEX_W + OFFSET_W;
    localparam int BUB_W  = $clog2(BUBBLE_CYCLES + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BUBBLE,
        ST_PAGE_SEL,
        ST_ADDR_LOAD,
        ST_FETCH,
        ST_REGION_UPD
    } fill_state_t;

    fill_state_t        state_q;
    fill_state_t        state_d;
    logic [ADDR_W-1:0]  region_base_q;
    logic [ADDR_W-1:0]  page_base_q;
    logic [ADDR_W-1:0]  spi_addr_q;
    logic [INDEX_W-1:0] fill_cnt_q;
    logic [BUB_W-1:0]   bubble_cnt_q;
    logic [DATA_W-1:0]  code_hold_q;
    logic               hit;
    logic               hit_q;
    logic               word_take;

    // Region base is page aligned, so a page number compare is the range check
    assign hit = (region_base_q != REGION_NONE) &&
                 (i_pc_fetch[ADDR_W-1:PG_LSB] == region_base_q[ADDR_W-1:PG_LSB]);

    assign word_take = (state_q == ST_FETCH) && i_spi_ready && !i_bypass;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (!hit)
                    state_d = ST_BUBBLE;
            ST_BUBBLE:
                if (bubble_cnt_q == BUB_W'(BUBBLE_CYCLES - 1))
                    state_d = ST_PAGE_SEL;
            ST_PAGE_SEL:   state_d = ST_ADDR_LOAD;
            ST_ADDR_LOAD:  state_d = ST_FETCH;
            ST_FETCH:
                if (word_take && (&fill_cnt_q))
                    state_d = ST_REGION_UPD;
            ST_REGION_UPD: state_d = ST_IDLE;
            default:       state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q       <= ST_IDLE;
            region_base_q <= REGION_NONE;
            spi_addr_q    <= '0;
            fill_cnt_q    <= '0;
            bubble_cnt_q  <= '0;
            hit_q         <= 1'b0;
        end
        else
        begin
            // Bypass parks the FSM in idle
            state_q <= i_bypass ? ST_IDLE : state_d;
            hit_q   <= (state_q == ST_IDLE) && hit && !i_bypass;

            if (state_q == ST_BUBBLE)
                bubble_cnt_q <= bubble_cnt_q + BUB_W'(1);
            else
                bubble_cnt_q <= '0;

            if (state_q == ST_ADDR_LOAD)
            begin
                spi_addr_q <= page_base_q;
                fill_cnt_q <= '0;
            end
            else if (word_take)
            begin
                spi_addr_q <= spi_addr_q + ADDR_W'(4);
                fill_cnt_q <= fill_cnt_q + INDEX_W'(1);
            end

            if (state_q == ST_REGION_UPD)
                region_base_q <= page_base_q;
        end
    end

    // Page of the missing PC and the word the core currently sees
    always_ff @(posedge clk)
    begin
        if (state_q == ST_PAGE_SEL)
            page_base_q <= {i_pc_fetch[ADDR_W-1:PG_LSB], {PG_LSB{1'b0}}};
        code_hold_q <= (i_bypass && i_spi_ready) ? i_spi_data : o_code_fetch;
    end

    assign o_region_base    = region_base_q;
    assign o_code_fetch     = hit_q ? i_ram_rdata : code_hold_q;
    assign o_clk_enable     = i_bypass ? i_spi_ready : ((state_q == ST_IDLE) && hit);
    assign o_i_cache_miss   = i_bypass ? !i_spi_ready : !hit;
    assign o_core_bubble    = (state_q == ST_BUBBLE);
    assign o_spi_address    = i_bypass ? i_pc_fetch : spi_addr_q;
    assign o_spi_addr_valid = i_bypass || (state_q == ST_FETCH);

    // RAM port is shared between fill writes and core reads
    assign o_ram_we    = word_take;
    assign o_ram_index = (state_q == ST_FETCH) ? fill_cnt_q : i_pc_fetch[PG_LSB-1:OFFSET_W];
    assign o_ram_wdata = i_spi_data;

    bubble_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(o_core_bubble) |-> ##BUBBLE_CYCLES !o_core_bubble);

    // Each fill write lands in the slot of the flash word being read
    fill_write_slot: assert property (@(posedge clk) disable iff (!rst_n)
        o_ram_we |-> (o_ram_index == o_spi_address[PG_LSB-1:OFFSET_W]) &&
                     (o_spi_address[ADDR_W-1:PG_LSB] == page_base_q[ADDR_W-1:PG_LSB]));

endmodule

//--- icache_top.f
common/icache_pkg.sv
hdl/icache_ram.sv
hdl/icache_regs.sv
icache_fill/icache_fill_ctrl.sv
hdl/icache_top.sv
verification/icache_checker.sv
verification/tb_icache_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the instruction cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f icache_top.f \
    --top-module tb_icache_top \
    -Mdir obj_dir \
    -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

//--- verification/icache_cases.txt
# test, operation, word or offset, expected value or write data
# ops RD RDERR WR WRERR take an offset, MISS HIT PAGE BYPASS take a PC
rd_region_reset   RD      4        ffffffff
first_miss        MISS    00004010 5
hit_same          HIT     00004010 0
page_sweep        PAGE    00004000 0
rd_region_a       RD      4        00004000
wr_region         WR      4        12345678
rd_region_kept    RD      4        00004000
rd_unmapped       RDERR   8        0
wr_unmapped       WRERR   c        1
miss_page_b       MISS    000087fc 5
rd_region_b       RD      4        00008400
hit_b             HIT     00008400 0
old_page_miss     MISS    00004020 5
wr_bypass_on      WR      0        1
rd_bypass         RD      0        1
bypass_far        BYPASS  00010000 0
bypass_near       BYPASS  00004024 0
bypass_last       BYPASS  00004028 0
wr_bypass_off     WR      0        0
rd_ctrl_off       RD      0        0
hit_after_bypass  HIT     0000402c 0

//--- verification/icache_checker.sv
// Watches the core side of the cache and checks every completed fetch
// Expected word for address A is A ^ FLASH_KEY, the flash model's rule
// Also measures each bubble run for the fetch tests to compare
`timescale 1ns/1ns

module icache_checker #(
    parameter logic [31:0] FLASH_KEY = 32'h5a5a_a5a5
)
(
    input logic        clk,
    input logic        rst_n,
    input logic        i_check_en,
    input logic [31:0] i_pc_fetch,
    input logic [31:0] i_code_fetch,
    input logic        i_clk_enable,
    input logic        i_core_bubble
);

    string       test_name = "reset";
    int          error_count = 0;
    int          test_count = 0;
    int          failed_count = 0;
    int          errors_at_start = 0;
    int          bubble_len = 0;
    int          last_bubble_len = 0;
    int          bubble_runs = 0;
    logic        pending = 1'b0;
    logic [31:0] pending_pc = '0;

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0s %0s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Test %0s failed because %0s", test_name, what);
        error_count++;
    endtask

    task automatic end_test();
        test_count++;
        if (error_count != errors_at_start)
        begin
            failed_count++;
            $display("FAIL %0s", test_name);
        end
        else
            $display("PASS %0s", test_name);
    endtask

    // Fetch completes on a rising edge with clock enable, word shows one cycle later
    always @(posedge clk)
    begin
        pending    <= rst_n && i_check_en && i_clk_enable;
        pending_pc <= i_pc_fetch;
        if (rst_n && i_core_bubble)
            bubble_len <= bubble_len + 1;
        else if (bubble_len != 0)
        begin
            last_bubble_len <= bubble_len;
            bubble_runs     <= bubble_runs + 1;
            bubble_len      <= 0;
        end
    end

    always @(negedge clk)
    begin
        if (pending)
            compare($sformatf("fetch of 0x%08h", pending_pc), pending_pc ^ FLASH_KEY, i_code_fetch);
    end

endmodule

//--- verification/tb_icache_top.sv
// Testbench for the instruction cache with tests read from icache_cases.txt
// Flash model answers address A with A ^ 5a5aa5a5 after 0 to 3 idle cycles
`timescale 1ns/1ns

module tb_icache_top;

    localparam logic [31:0] FLASH_KEY  = 32'h5a5a_a5a5;
    localparam int          WAIT_LIMIT = 4000;

    logic        clk;
    logic        rst_n;
    logic        check_en;
    logic [31:0] i_pc_fetch;
    logic [31:0] i_spi_data = '0;
    logic [31:0] i_wdata;
    logic        i_spi_ready = 1'b0;
    logic        i_awvalid;
    logic        i_wvalid;
    logic        i_bready;
    logic        i_arvalid;
    logic        i_rready;
    logic [3:0]  i_awaddr;
    logic [3:0]  i_wstrb;
    logic [3:0]  i_araddr;
    logic [31:0] o_code_fetch;
    logic [31:0] o_spi_address;
    logic [31:0] o_rdata;
    logic        o_clk_enable;
    logic        o_i_cache_miss;
    logic        o_core_bubble;
    logic        o_spi_addr_valid;
    logic        o_awready;
    logic        o_wready;
    logic        o_bvalid;
    logic        o_arready;
    logic        o_rvalid;
    logic [1:0]  o_bresp;
    logic [1:0]  o_rresp;
    logic [31:0] rng_state = 32'h8eaa_6e58;
    int          delay_left = 0;
    int          prev_runs = 0;

    icache_top #(.INDEX_W(8), .BUBBLE_CYCLES(5)) icache_top_inst (.*);

    icache_checker #(.FLASH_KEY(FLASH_KEY)) checker_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_check_en    (check_en),
        .i_pc_fetch    (i_pc_fetch),
        .i_code_fetch  (o_code_fetch),
        .i_clk_enable  (o_clk_enable),
        .i_core_bubble (o_core_bubble)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Flash master gives one ready pulse per word with a gap after each
    always @(negedge clk)
    begin
        if (!rst_n)
            i_spi_ready = 1'b0;
        else if (i_spi_ready)
        begin
            i_spi_ready = 1'b0;
            rng_state   = xorshift(rng_state);
            delay_left  = int'(rng_state[1:0]);
        end
        else if (o_spi_addr_valid)
        begin
            if (delay_left == 0)
            begin
                i_spi_data  = o_spi_address ^ FLASH_KEY;
                i_spi_ready = 1'b1;
            end
            else
                delay_left--;
        end
    end

    task automatic timeout_abort(input string what);
        $display("Timeout while waiting for %0s in test %0s", what, checker_inst.test_name);
        $display("Something failed");
        $finish;
    endtask

    task automatic axi_read(input logic [3:0] off, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        n = 0;
        @(negedge clk);
        i_araddr  = off;
        i_arvalid = 1'b1;
        i_rready  = 1'b1;
        do
        begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timeout_abort("arready");
        end while (!o_arready);
        @(negedge clk);
        i_arvalid = 1'b0;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timeout_abort("rvalid");
        end while (!o_rvalid);
        data = o_rdata;
        resp = o_rresp;
        @(negedge clk);
        i_rready = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] off, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        n = 0;
        @(negedge clk);
        i_awaddr  = off;
        i_wdata   = data;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        i_bready  = 1'b1;
        do
        begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timeout_abort("awready and wready");
        end while (!(o_awready && o_wready));
        @(negedge clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT)
                timeout_abort("bvalid");
        end while (!o_bvalid);
        resp = o_bresp;
        @(negedge clk);
        i_bready = 1'b0;
    endtask

    // Presents one PC and waits for the edge that completes it
    task automatic fetch_word(input logic [31:0] addr, output int stalls,
                              output logic miss_first, output logic spi_ok);
        stalls = 0;
        @(negedge clk);
        i_pc_fetch = addr;
        do
        begin
            @(posedge clk);
            if (stalls == 0)
                miss_first = o_i_cache_miss;
            spi_ok = o_spi_addr_valid && (o_spi_address == addr);
            if (!o_clk_enable)
            begin
                stalls++;
                if (stalls > WAIT_LIMIT)
                    timeout_abort("clock enable");
            end
        end while (!o_clk_enable);
    endtask

    task automatic run_case(input string name, input string op, input logic [31:0] addr,
                            input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        int          stalls;
        int          n;
        logic        miss_first;
        logic        spi_ok;
        checker_inst.start_test(name);
        case (op)
            "RD", "RDERR":
            begin
                axi_read(addr[3:0], data, resp);
                checker_inst.compare("read data", exp, data);
                checker_inst.compare("read resp", (op == "RD") ? 32'd0 : 32'd2, 32'(resp));
            end
            "WR", "WRERR":
            begin
                axi_write(addr[3:0], exp, resp);
                checker_inst.compare("write resp", (op == "WR") ? 32'd0 : 32'd2, 32'(resp));
            end
            "HIT", "PAGE":
            begin
                for (int i = 0; i < ((op == "PAGE") ? 256 : 1); i++)
                begin
                    fetch_word(addr + 32'(4 * i), stalls, miss_first, spi_ok);
                    if (stalls != 0)
                        checker_inst.report_failure($sformatf("0x%08h stalled", addr + 4 * i));
                end
            end
            "MISS":
            begin
                fetch_word(addr, stalls, miss_first, spi_ok);
                if (!miss_first)
                    checker_inst.report_failure("the miss flag stayed low");
                if (checker_inst.bubble_runs != prev_runs + 1)
                    checker_inst.report_failure("there was not exactly one bubble");
                checker_inst.compare("bubble cycles", exp, 32'(checker_inst.last_bubble_len));
            end
            "BYPASS":
            begin
                // Change the PC only right after a flash pulse
                n = 0;
                do
                begin
                    @(posedge clk);
                    n++;
                    if (n > WAIT_LIMIT)
                        timeout_abort("flash ready");
                end while (!i_spi_ready);
                fetch_word(addr, stalls, miss_first, spi_ok);
                if (!spi_ok)
                    checker_inst.report_failure("the flash did not see the PC");
            end
            default:
                checker_inst.report_failure($sformatf("operation %0s is unknown", op));
        endcase
        if ((op == "HIT" || op == "PAGE" || op == "BYPASS") &&
            checker_inst.bubble_runs != prev_runs)
            checker_inst.report_failure("a bubble appeared");
        if (op == "MISS" || op == "HIT" || op == "PAGE" || op == "BYPASS")
            prev_runs = checker_inst.bubble_runs;
        repeat (2) @(negedge clk);
        checker_inst.end_test();
    endtask

    initial
    begin
        int          fd;
        int          code;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] exp;
        rst_n = 1'b0;
        check_en = 1'b0;
        i_pc_fetch = 32'h0000_4010;
        i_awaddr = '0;
        i_awvalid = 1'b0;
        i_wdata = '0;
        i_wstrb = 4'hf;
        i_wvalid = 1'b0;
        i_bready = 1'b0;
        i_araddr = '0;
        i_arvalid = 1'b0;
        i_rready = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_en = 1'b1;
        fd = $fopen("verification/icache_cases.txt", "r");
        if (fd == 0)
            $display("Could not open the cases file");
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                if (code > 0 && $sscanf(line, "%s %s %h %h", name, op, addr, exp) == 4)
                    run_case(name, op, addr, exp);
            end
            $fclose(fd);
        end
        $display("Tests run %0d, failed %0d, errors %0d", checker_inst.test_count,
                 checker_inst.failed_count, checker_inst.error_count);
        if (fd != 0 && checker_inst.test_count > 0 && checker_inst.error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
